// ==== sources.f ====
+incdir+verification
hw/meas_pkg.sv
hw/net_pkg.sv
hw/crc32_gen.sv
hw/apb_regs.sv
hw/tx_ctrl.sv
hw/frame_builder.sv
hw/arp_rx.sv
hw/rate_meter.sv
hw/measure_top.sv
verification/tb_measure.sv

// ==== verification/tb_frame_model.svh ====
typedef logic [7:0] byte_q_t[$];

// ----------------------------------------------------------------------
// Byte builders
// ----------------------------------------------------------------------
function automatic void put_be(ref byte_q_t f, input logic [63:0] v, input int n);
  for (int k = n - 1; k >= 0; k--) begin
    f.push_back(v[8*k +: 8]);   // Most significant byte first
  end
endfunction

// Ethernet FCS over the whole queue, complemented
function automatic logic [31:0] crc32_calc(input byte_q_t f);
  logic [31:0] c;
  c = 32'hFFFF_FFFF;
  foreach (f[i]) begin
    c = c ^ {24'h0, f[i]};
    for (int b = 0; b < 8; b++) begin
      c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
    end
  end
  return ~c;
endfunction

// Pads to len - 4, appends the FCS and puts preamble and SFD in front
function automatic void seal_frame(ref byte_q_t f, input int len);
  logic [31:0] fcs;
  while (f.size() < len - 4) begin
    f.push_back(8'h00);
  end
  fcs = crc32_calc(f);
  for (int k = 0; k < 4; k++) begin
    f.push_back(fcs[8*k +: 8]);  // Low byte goes out first
  end
  f.push_front(8'hD5);
  for (int k = 0; k < 7; k++) begin
    f.push_front(8'h55);
  end
endfunction

function automatic logic [15:0] ip_checksum(input byte_q_t f, input int first);
  logic [31:0] s;
  s = 32'h0;
  for (int i = 0; i < 20; i += 2) begin
    s = s + {16'h0, f[first+i], f[first+i+1]};
  end
  s = (s & 32'hFFFF) + (s >> 16);
  s = (s & 32'hFFFF) + (s >> 16);
  return ~s[15:0];
endfunction

function automatic byte_q_t arp_frame(input logic [47:0] eth_dst, input logic [47:0] eth_src,
                                      input logic [15:0] op, input logic [47:0] sha,
                                      input logic [31:0] spa, input logic [47:0] tha,
                                      input logic [31:0] tpa);
  byte_q_t f;
  f = {};
  put_be(f, eth_dst, 6);
  put_be(f, eth_src, 6);
  put_be(f, 16'h0806, 2);
  put_be(f, 16'h0001, 2);   // Ethernet hardware
  put_be(f, 16'h0800, 2);
  put_be(f, 16'h0604, 2);   // Address sizes
  put_be(f, op, 2);
  put_be(f, sha, 6);
  put_be(f, spa, 4);
  put_be(f, tha, 6);
  put_be(f, tpa, 4);
  seal_frame(f, 64);
  return f;
endfunction

function automatic byte_q_t ipv4_frame(input logic [47:0] dmac, input logic [47:0] smac,
                                       input logic [31:0] sip, input logic [31:0] dip,
                                       input int len, input logic [15:0] id,
                                       input logic [31:0] ts);
  byte_q_t f;
  logic [15:0] cs;
  f = {};
  put_be(f, dmac, 6);
  put_be(f, smac, 6);
  put_be(f, 16'h0800, 2);
  put_be(f, 16'h4500, 2);
  put_be(f, len - 18, 2);
  put_be(f, id, 2);
  put_be(f, 16'h0000, 2);   // Flags and fragment
  put_be(f, 16'h4011, 2);   // TTL 64, UDP
  put_be(f, 16'h0000, 2);
  put_be(f, sip, 4);
  put_be(f, dip, 4);
  cs = ip_checksum(f, 14);
  f[24] = cs[15:8];
  f[25] = cs[7:0];
  put_be(f, 16'd3422, 2);
  put_be(f, 16'd3422, 2);
  put_be(f, len - 38, 2);
  put_be(f, 16'h0000, 2);
  put_be(f, 40'hCC00CC00CC, 5);
  put_be(f, ts, 4);
  seal_frame(f, len);
  return f;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] r;
  r = x;
  r = r ^ (r << 13);
  r = r ^ (r >> 17);
  r = r ^ (r << 5);
  return r;
endfunction

// ==== verification/tb_measure.sv ====
`timescale 1ns/1ps

module tb_measure;

  localparam int test_len = 96;

  logic               gmii_0_tx_clk;
  logic               sys_rst;
  meas_pkg::apb_req_t apb;
  logic [31:0]        prdata;
  logic [7:0]         gmii_0_txd, gmii_0_rxd;
  logic               gmii_0_tx_en, gmii_0_rx_dv;

  int          n_checks, n_errors;
  logic [47:0] host_mac, gw_mac;
  logic [31:0] host_ip, gw_addr, peer_ip, last_ts;
  logic [15:0] next_id;

  `include "tb_frame_model.svh"

  measure_top #(.tick_cycles(4000)) uut (
    .gmii_0_tx_clk, .sys_rst, .apb, .prdata, .gmii_0_txd, .gmii_0_tx_en,
    .gmii_0_rxd, .gmii_0_rx_dv
  );

  initial begin
    gmii_0_tx_clk = 1'b0;
    forever #4 gmii_0_tx_clk = ~gmii_0_tx_clk;
  end

  // ----------------------------------------------------------------------
  // Checks and bus tasks
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
      n_errors++;
    assert (got === exp)
      else $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
  endtask

  task automatic check_true(input logic cond, input string msg);
    n_checks++;
    if (cond !== 1'b1)
      n_errors++;
    assert (cond === 1'b1)
      else $display("%s", msg);
  endtask

  task automatic write_reg(input meas_pkg::reg_addr_e a, input logic [31:0] d);
    apb.sel    = 1'b1;
    apb.enable = 1'b0;
    apb.write  = 1'b1;
    apb.addr   = a;
    apb.wdata  = d;
    @(negedge gmii_0_tx_clk);
    apb.enable = 1'b1;              // Access phase
    @(negedge gmii_0_tx_clk);
    apb = '0;
  endtask

  task automatic read_reg(input meas_pkg::reg_addr_e a, output logic [31:0] d);
    apb.sel    = 1'b1;
    apb.enable = 1'b0;
    apb.write  = 1'b0;
    apb.addr   = a;
    apb.wdata  = 32'h0;
    @(negedge gmii_0_tx_clk);
    apb.enable = 1'b1;
    #2;
    d = prdata;                     // Mid low phase
    @(negedge gmii_0_tx_clk);
    apb = '0;
  endtask

  task automatic expect_reg(input meas_pkg::reg_addr_e a, input logic [31:0] exp);
    logic [31:0] d;
    read_reg(a, d);
    check_value(a.name(), d, exp);
  endtask

  // Idle counts the low cycles seen before tx_en rises
  task automatic capture_frame(output byte_q_t q, output int idle);
    int n;
    q = {};
    idle = 0;
    n = 0;
    while (!gmii_0_tx_en && idle < 6000) begin
      idle++;
      @(negedge gmii_0_tx_clk);
    end
    check_true(gmii_0_tx_en, "Timed out waiting for a frame on GMII");
    while (gmii_0_tx_en && n < 1600) begin
      q.push_back(gmii_0_txd);
      n++;
      @(negedge gmii_0_tx_clk);
    end
    check_true(n < 1600, "Frame on GMII did not end before the timeout");
  endtask

  task automatic compare_frame(input string what, input byte_q_t got, input byte_q_t exp);
    int pos;
    pos = 0;
    check_value({"gmii_0_tx_en length of ", what}, got.size(), exp.size());
    if (got.size() == exp.size() && exp.size() > 0) begin
      while (pos < exp.size() - 1 && got[pos] === exp[pos])
        pos++;
      check_value($sformatf("gmii_0_txd[%0d] of %s", pos, what), got[pos], exp[pos]);
    end
  endtask

  task automatic check_ipv4(input byte_q_t got);
    byte_q_t     exp;
    logic [31:0] ts;
    ts = {got[55], got[56], got[57], got[58]};   // Payload offset 47
    exp = ipv4_frame(gw_mac, host_mac, host_ip, peer_ip, test_len, next_id, ts);
    compare_frame($sformatf("IPv4 frame id %0d", next_id), got, exp);
    check_true(ts > last_ts, "IPv4 timestamp did not rise from the previous frame");
    last_ts = ts;
    next_id++;
  endtask

  task automatic send_arp_reply(input logic [31:0] sender_ip);
    byte_q_t f;
    f = arp_frame(host_mac, gw_mac, 16'd2, gw_mac, sender_ip, host_mac, host_ip);
    foreach (f[i]) begin
      gmii_0_rx_dv = 1'b1;
      gmii_0_rxd   = f[i];
      @(negedge gmii_0_tx_clk);
    end
    gmii_0_rx_dv = 1'b0;
    gmii_0_rxd   = 8'h00;
    @(negedge gmii_0_tx_clk);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic reset_and_registers();
    int low;
    low = 0;
    for (int i = 0; i < 20; i++) begin
      if (gmii_0_tx_en === 1'b0)
        low++;
      @(negedge gmii_0_tx_clk);
    end
    check_value("gmii_0_tx_en low cycles after reset", low, 20);
    expect_reg(meas_pkg::dst_mac_hi, 32'h0);
    expect_reg(meas_pkg::dst_mac_lo, 32'h0);
    expect_reg(meas_pkg::pps, 32'h0);
    expect_reg(meas_pkg::throughput, 32'h0);
    expect_reg(meas_pkg::ctrl, 32'h0);
    write_reg(meas_pkg::frame_len, 32'd20);
    expect_reg(meas_pkg::frame_len, 32'd64);       // Clamped up
    write_reg(meas_pkg::ifg, 32'd3);
    expect_reg(meas_pkg::ifg, 32'd12);
    write_reg(meas_pkg::src_mac_hi, {16'h0, host_mac[47:32]});
    write_reg(meas_pkg::src_mac_lo, host_mac[31:0]);
    write_reg(meas_pkg::src_ip, host_ip);
    write_reg(meas_pkg::gw_ip, gw_addr);
    write_reg(meas_pkg::dst_ip, peer_ip);
    write_reg(meas_pkg::frame_len, test_len);
    expect_reg(meas_pkg::src_mac_hi, {16'h0, host_mac[47:32]});
    expect_reg(meas_pkg::src_mac_lo, host_mac[31:0]);
    expect_reg(meas_pkg::src_ip, host_ip);
    expect_reg(meas_pkg::gw_ip, gw_addr);
    expect_reg(meas_pkg::dst_ip, peer_ip);
    expect_reg(meas_pkg::frame_len, test_len);
  endtask

  task automatic arp_request_retry();
    byte_q_t got, exp;
    int      idle;
    exp = arp_frame(48'hFFFF_FFFF_FFFF, host_mac, 16'd1, host_mac, host_ip, 48'h0, gw_addr);
    write_reg(meas_pkg::ctrl, 32'h1);
    capture_frame(got, idle);
    compare_frame("first ARP request", got, exp);
    capture_frame(got, idle);                       // No reply sent
    check_value("gmii_0_tx_en idle cycles before ARP retry", idle, meas_pkg::arp_wait_cycles);
    compare_frame("repeated ARP request", got, exp);
  endtask

  task automatic arp_reply_match();
    byte_q_t got;
    int      idle;
    send_arp_reply(gw_addr ^ 32'h1);
    expect_reg(meas_pkg::dst_mac_hi, 32'h0);
    expect_reg(meas_pkg::dst_mac_lo, 32'h0);
    fork
      begin
        send_arp_reply(gw_addr);
        expect_reg(meas_pkg::dst_mac_hi, {16'h0, gw_mac[47:32]});
        expect_reg(meas_pkg::dst_mac_lo, gw_mac[31:0]);
      end
      capture_frame(got, idle);   // First test frame starts before the reply ends
    join
    check_value("gmii_0_txd ethertype", {got[20], got[21]}, 32'h0800);
    check_ipv4(got);
  endtask

  task automatic ipv4_frames();
    byte_q_t got;
    int      idle;
    for (int i = 0; i < 3; i++) begin
      capture_frame(got, idle);
      check_value("gmii_0_tx_en idle cycles", idle, 32'd12);
      check_ipv4(got);
    end
  endtask

  task automatic gap_length();
    byte_q_t got;
    int      idle;
    int      gaps[2] = '{40, 20};
    for (int k = 0; k < 2; k++) begin
      write_reg(meas_pkg::ifg, gaps[k]);            // Lands inside the running gap
      capture_frame(got, idle);
      check_ipv4(got);
      capture_frame(got, idle);
      check_value("gmii_0_tx_en idle cycles", idle, gaps[k]);
      check_ipv4(got);
    end
  endtask

  task automatic meter_and_rearp();
    logic [31:0] pps_a, pps_b, thr;
    int          polls, tries, idle;
    byte_q_t     got, exp;
    polls = 0;
    pps_a = 32'h0;
    while (pps_a == 32'h0 && polls < 10000) begin
      read_reg(meas_pkg::pps, pps_a);
      polls++;
    end
    check_true(pps_a != 32'h0, "pps stayed zero until the timeout");
    tries = 0;
    pps_b = ~pps_a;
    while (pps_a != pps_b && tries < 4) begin       // Retry if a tick fell between reads
      read_reg(meas_pkg::pps, pps_a);
      read_reg(meas_pkg::throughput, thr);
      read_reg(meas_pkg::pps, pps_b);
      tries++;
    end
    check_true(pps_a == pps_b, "pps kept changing between consecutive reads");
    check_value("throughput", thr, pps_a * test_len);
    write_reg(meas_pkg::ctrl, 32'h3);
    expect_reg(meas_pkg::dst_mac_hi, 32'h0);
    expect_reg(meas_pkg::dst_mac_lo, 32'h0);
    exp = arp_frame(48'hFFFF_FFFF_FFFF, host_mac, 16'd1, host_mac, host_ip, 48'h0, gw_addr);
    got = {};
    tries = 0;
    while (!(got.size() == 72 && got[20] == 8'h08 && got[21] == 8'h06) && tries < 3) begin
      capture_frame(got, idle);
      tries++;
    end
    compare_frame("ARP request after req_arp", got, exp);
  endtask

  initial begin
    logic [31:0] rng;
    n_checks     = 0;
    n_errors     = 0;
    next_id      = 16'h0;
    last_ts      = 32'h0;
    sys_rst      = 1'b1;
    apb          = '0;
    gmii_0_rxd   = 8'h00;
    gmii_0_rx_dv = 1'b0;
    rng = xorshift32(32'd22);
    host_mac = {16'h0200, rng};                     // Locally administered unicast
    rng = xorshift32(rng);
    host_ip = {8'd10, rng[23:0]};
    rng = xorshift32(rng);
    gw_mac  = {16'h0A00, rng};
    gw_addr = {host_ip[31:8], 8'd1};
    peer_ip = 32'hC0A8_0114;
    repeat (3) @(negedge gmii_0_tx_clk);
    sys_rst = 1'b0;

    reset_and_registers();
    arp_request_retry();
    arp_reply_match();
    ipv4_frames();
    gap_length();
    meter_and_rearp();

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== hw/measure_top.sv ====
`timescale 1ns/1ps

module measure_top #(
  parameter int unsigned tick_cycles = meas_pkg::one_sec_cycles
) (
  input  logic                gmii_0_tx_clk,
  input  logic                sys_rst,
  input  meas_pkg::apb_req_t  apb,
  output logic [31:0]         prdata,
  output logic [7:0]          gmii_0_txd,
  output logic                gmii_0_tx_en,
  input  logic [7:0]          gmii_0_rxd,
  input  logic                gmii_0_rx_dv
);

  meas_pkg::tx_cfg_t   cfg;
  meas_pkg::tx_state_e state;
  net_pkg::gmii_byte_t tx;
  logic                req_arp, mac_valid, frame_done;
  logic [15:0]         byte_idx, frame_bytes;
  logic [47:0]         dst_mac;
  logic [31:0]         pps, throughput, timestamp;

  apb_regs u_regs (
    .gmii_0_tx_clk, .sys_rst, .apb, .prdata, .cfg, .req_arp,
    .dst_mac, .pps, .throughput
  );

  tx_ctrl u_ctrl (
    .gmii_0_tx_clk, .sys_rst, .cfg, .mac_valid, .state, .byte_idx,
    .frame_done, .frame_bytes
  );

  frame_builder u_builder (
    .gmii_0_tx_clk, .sys_rst, .state, .byte_idx, .cfg, .dst_mac, .timestamp, .tx
  );

  arp_rx u_arp (
    .gmii_0_tx_clk, .sys_rst, .rxd(gmii_0_rxd), .rx_dv(gmii_0_rx_dv), .cfg,
    .req_arp, .dst_mac, .mac_valid
  );

  rate_meter #(.tick_cycles(tick_cycles)) u_meter (
    .gmii_0_tx_clk, .sys_rst, .frame_done, .frame_bytes, .pps, .throughput, .timestamp
  );

  assign gmii_0_tx_en = tx.en;    // GMII pins
  assign gmii_0_txd   = tx.data;

endmodule

// ==== hw/rate_meter.sv ====
`timescale 1ns/1ps

module rate_meter #(
  parameter int unsigned tick_cycles = meas_pkg::one_sec_cycles
) (
  input  logic        gmii_0_tx_clk,
  input  logic        sys_rst,
  input  logic        frame_done,
  input  logic [15:0] frame_bytes,
  output logic [31:0] pps,
  output logic [31:0] throughput,
  output logic [31:0] timestamp
);

  logic [31:0] tick_cnt, frame_acc, byte_acc;
  logic        tick;

  assign tick = (tick_cnt == 32'h0);

  always_ff @(posedge gmii_0_tx_clk) begin
    if (sys_rst) begin
      tick_cnt   <= 32'(tick_cycles - 1);
      frame_acc  <= 32'h0;
      byte_acc   <= 32'h0;
      pps        <= 32'h0;
      throughput <= 32'h0;
      timestamp  <= 32'h0;
    end else begin
      timestamp <= timestamp + 32'd1;   // Free running cycle count
      if (tick) begin
        tick_cnt   <= 32'(tick_cycles - 1);
        pps        <= frame_acc;
        throughput <= byte_acc;
        frame_acc  <= {31'h0, frame_done};  // Counts toward the new interval
        byte_acc   <= frame_done ? {16'h0, frame_bytes} : 32'h0;
      end else begin
        tick_cnt <= tick_cnt - 32'd1;
        if (frame_done) begin
          frame_acc <= frame_acc + 32'd1;
          byte_acc  <= byte_acc + {16'h0, frame_bytes};
        end
      end
    end
  end

endmodule

// ==== hw/arp_rx.sv ====
`timescale 1ns/1ps

module arp_rx (
  input  logic               gmii_0_tx_clk,
  input  logic               sys_rst,
  input  logic [7:0]         rxd,
  input  logic               rx_dv,
  input  meas_pkg::tx_cfg_t  cfg,
  input  logic               req_arp,
  output logic [47:0]        dst_mac,
  output logic               mac_valid
);

  logic        in_frame, req_seen, accept;
  logic [13:0] rx_cnt;
  logic [47:0] rx_src_mac;
  logic [15:0] rx_type, rx_opcode;
  logic [31:0] rx_sender_ip, rx_target_ip;

  function automatic logic in_field(input logic [13:0] cnt, input int base, input int n);
    return (cnt >= base) && (cnt < base + n);
  endfunction

  // Checked once the target IP is complete
  assign accept = in_frame && (rx_cnt == 14'(net_pkg::rx_off_target_ip + 4)) &&
                  (rx_type == net_pkg::ethertype_arp) && (rx_opcode == net_pkg::reply) &&
                  (rx_sender_ip == cfg.gw_ip) && (rx_target_ip == cfg.src_ip) &&
                  !rx_src_mac[40] && !req_seen && !req_arp;

  always_ff @(posedge gmii_0_tx_clk) begin
    if (sys_rst) begin
      in_frame  <= 1'b0;
      rx_cnt    <= 14'h0;
      req_seen  <= 1'b0;
      dst_mac   <= 48'h0;
      mac_valid <= 1'b0;
    end else begin
      if (!rx_dv) begin
        in_frame <= 1'b0;
        rx_cnt   <= 14'h0;
      end else if (!in_frame) begin
        if (rxd == net_pkg::sfd_byte) begin
          in_frame <= 1'b1;   // Next byte is the destination MAC
          req_seen <= 1'b0;
        end
      end else begin
        rx_cnt <= rx_cnt + 14'd1;
      end
      if (req_arp) begin
        dst_mac   <= 48'h0;
        mac_valid <= 1'b0;
        req_seen  <= 1'b1;    // Drop replies already in flight
      end else if (accept) begin
        dst_mac   <= rx_src_mac;
        mac_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge gmii_0_tx_clk) begin
    if (in_frame && rx_dv) begin
      if (in_field(rx_cnt, net_pkg::rx_off_src_mac, 6))
        rx_src_mac <= {rx_src_mac[39:0], rxd};
      if (in_field(rx_cnt, net_pkg::rx_off_type, 2))
        rx_type <= {rx_type[7:0], rxd};
      if (in_field(rx_cnt, net_pkg::rx_off_opcode, 2))
        rx_opcode <= {rx_opcode[7:0], rxd};
      if (in_field(rx_cnt, net_pkg::rx_off_sender_ip, 4))
        rx_sender_ip <= {rx_sender_ip[23:0], rxd};
      if (in_field(rx_cnt, net_pkg::rx_off_target_ip, 4))
        rx_target_ip <= {rx_target_ip[23:0], rxd};
    end
  end

endmodule

// ==== hw/frame_builder.sv ====
`timescale 1ns/1ps

module frame_builder (
  input  logic                 gmii_0_tx_clk,
  input  logic                 sys_rst,
  input  meas_pkg::tx_state_e  state,
  input  logic [15:0]          byte_idx,
  input  meas_pkg::tx_cfg_t    cfg,
  input  logic [47:0]          dst_mac,
  input  logic [31:0]          timestamp,
  output net_pkg::gmii_byte_t  tx
);

  logic        is_arp, is_v4, in_frame, in_body, in_fcs;
  logic        crc_init, crc_en;
  logic [15:0] len, off, ip_len, udp_len, ipv4_id, ip_csum;
  logic [19:0] ip_sum;
  logic [31:0] ts_hold, crc;
  logic [7:0]  arp_byte, v4_byte, nxt_byte;

  // Byte k of an n byte big endian field
  function automatic logic [7:0] be_byte(input logic [63:0] v, input int n, input int k);
    return v[8*(n-1-k) +: 8];
  endfunction

  assign is_arp   = (state == meas_pkg::arp_req);
  assign is_v4    = (state == meas_pkg::send_v4);
  assign in_frame = is_arp | is_v4;
  assign len      = is_arp ? net_pkg::arp_frame_len : cfg.frame_len;
  assign off      = byte_idx - meas_pkg::preamble_len;  // Offset from destination MAC
  assign in_body  = in_frame && (byte_idx >= meas_pkg::preamble_len);
  assign in_fcs   = in_body && (off >= len - 16'd4);
  assign crc_init = in_frame && !in_body;
  assign crc_en   = in_body && !in_fcs;
  assign ip_len   = cfg.frame_len - net_pkg::ipv4_hdr_offset;
  assign udp_len  = cfg.frame_len - net_pkg::udp_len_offset;
  assign ip_csum  = ~ip_sum[15:0];

  // ----------------------------------------------------------------------
  // Frame layouts
  // ----------------------------------------------------------------------
  always_comb begin
    arp_byte = 8'h00;  // Padding and zero target MAC
    case (off) inside
      [0:5]:   arp_byte = 8'hFF;                                   // Broadcast
      [6:11]:  arp_byte = be_byte(cfg.src_mac, 6, off - 6);
      [12:13]: arp_byte = be_byte(net_pkg::ethertype_arp, 2, off - 12);
      15:      arp_byte = 8'h01;                                   // Hardware Ethernet
      [16:17]: arp_byte = be_byte(net_pkg::ethertype_ipv4, 2, off - 16);
      18:      arp_byte = 8'h06;
      19:      arp_byte = 8'h04;
      [20:21]: arp_byte = be_byte(net_pkg::request, 2, off - 20);
      [22:27]: arp_byte = be_byte(cfg.src_mac, 6, off - 22);
      [28:31]: arp_byte = be_byte(cfg.src_ip, 4, off - 28);
      [38:41]: arp_byte = be_byte(cfg.gw_ip, 4, off - 38);
      default: ;
    endcase
  end

  always_comb begin
    v4_byte = 8'h00;   // Flags, UDP checksum and padding
    case (off) inside
      [0:5]:   v4_byte = be_byte(dst_mac, 6, off);
      [6:11]:  v4_byte = be_byte(cfg.src_mac, 6, off - 6);
      [12:13]: v4_byte = be_byte(net_pkg::ethertype_ipv4, 2, off - 12);
      14:      v4_byte = 8'h45;                                    // Version and IHL
      [16:17]: v4_byte = be_byte(ip_len, 2, off - 16);
      [18:19]: v4_byte = be_byte(ipv4_id, 2, off - 18);
      22:      v4_byte = net_pkg::ipv4_ttl;
      23:      v4_byte = net_pkg::ip_proto_udp;
      [24:25]: v4_byte = be_byte(ip_csum, 2, off - 24);
      [26:29]: v4_byte = be_byte(cfg.src_ip, 4, off - 26);
      [30:33]: v4_byte = be_byte(cfg.dst_ip, 4, off - 30);
      [34:35]: v4_byte = be_byte(net_pkg::udp_port, 2, off - 34);
      [36:37]: v4_byte = be_byte(net_pkg::udp_port, 2, off - 36);
      [38:39]: v4_byte = be_byte(udp_len, 2, off - 38);
      [42:46]: v4_byte = be_byte(net_pkg::magic_code, 5, off - 42);
      [47:50]: v4_byte = be_byte(ts_hold, 4, off - 47);
      default: ;
    endcase
  end

  always_comb begin
    if (!in_body)
      nxt_byte = (byte_idx == meas_pkg::preamble_len - 16'd1) ? net_pkg::sfd_byte
                                                              : net_pkg::preamble_byte;
    else if (in_fcs)
      nxt_byte = be_byte(crc, 4, off - (len - 16'd4));
    else
      nxt_byte = is_arp ? arp_byte : v4_byte;
  end

  crc32_gen u_crc (
    .gmii_0_tx_clk (gmii_0_tx_clk),
    .sys_rst       (sys_rst),
    .init          (crc_init),
    .data_en       (crc_en),
    .data          (nxt_byte),
    .crc           (crc)
  );

  always_ff @(posedge gmii_0_tx_clk) begin
    if (sys_rst) begin
      tx      <= '0;
      ipv4_id <= 16'h0;
    end else begin
      tx.en   <= in_frame;
      tx.data <= in_frame ? nxt_byte : 8'h00;
      if (is_v4 && (byte_idx == meas_pkg::preamble_len + len - 16'd1))
        ipv4_id <= ipv4_id + 16'd1;  // After the last FCS byte
    end
  end

  // Header checksum over the preamble, timestamp at payload start
  always_ff @(posedge gmii_0_tx_clk) begin
    if (is_v4 && byte_idx == 16'd0)
      ip_sum <= 20'h4500 + ip_len + ipv4_id + {net_pkg::ipv4_ttl, net_pkg::ip_proto_udp} +
                cfg.src_ip[31:16] + cfg.src_ip[15:0] + cfg.dst_ip[31:16] + cfg.dst_ip[15:0];
    else if (is_v4 && byte_idx <= 16'd2)
      ip_sum <= {4'h0, ip_sum[15:0]} + ip_sum[19:16];  // Fold carries twice
    if (is_v4 && in_body && off == 16'd42)
      ts_hold <= timestamp;
  end

endmodule

// ==== hw/tx_ctrl.sv ====
`timescale 1ns/1ps

module tx_ctrl (
  input  logic                 gmii_0_tx_clk,
  input  logic                 sys_rst,
  input  meas_pkg::tx_cfg_t    cfg,
  input  logic                 mac_valid,
  output meas_pkg::tx_state_e  state,
  output logic [15:0]          byte_idx,
  output logic                 frame_done,
  output logic [15:0]          frame_bytes
);

  logic [31:0] gap_cnt;
  logic [15:0] wait_cnt;
  logic [15:0] frame_end;
  logic        last_byte;

  // Index of the final FCS byte for the frame being sent
  assign frame_end = meas_pkg::preamble_len - 16'd1 +
                     ((state == meas_pkg::arp_req) ? net_pkg::arp_frame_len : cfg.frame_len);
  assign last_byte = (byte_idx == frame_end);

  always_ff @(posedge gmii_0_tx_clk) begin
    if (sys_rst) begin
      state       <= meas_pkg::idle;
      byte_idx    <= 16'h0;
      gap_cnt     <= 32'h0;
      wait_cnt    <= 16'h0;
      frame_done  <= 1'b0;
      frame_bytes <= 16'h0;
    end else begin
      frame_done <= 1'b0;
      case (state)
        meas_pkg::idle: begin
          if (cfg.enable)
            state <= mac_valid ? meas_pkg::send_v4 : meas_pkg::arp_req;
        end
        meas_pkg::arp_req: begin
          byte_idx <= last_byte ? 16'h0 : byte_idx + 16'd1;
          if (last_byte) begin
            state    <= meas_pkg::arp_wait;
            wait_cnt <= 16'(meas_pkg::arp_wait_cycles - 1);
          end
        end
        meas_pkg::arp_wait: begin
          wait_cnt <= wait_cnt - 16'd1;
          if (!cfg.enable) begin
            state <= meas_pkg::idle;
          end else if (mac_valid) begin
            state   <= meas_pkg::gap;       // One gap before the first test frame
            gap_cnt <= cfg.ifg - 32'd1;
          end else if (wait_cnt == 16'h0) begin
            state <= meas_pkg::arp_req;     // Timeout, ask again
          end
        end
        meas_pkg::send_v4: begin
          byte_idx <= last_byte ? 16'h0 : byte_idx + 16'd1;
          if (last_byte) begin
            state       <= meas_pkg::gap;
            gap_cnt     <= cfg.ifg - 32'd1;
            frame_done  <= 1'b1;
            frame_bytes <= cfg.frame_len;
          end
        end
        meas_pkg::gap: begin
          gap_cnt <= gap_cnt - 32'd1;
          if (gap_cnt == 32'h0) begin
            if (!cfg.enable)
              state <= meas_pkg::idle;
            else if (!mac_valid)
              state <= meas_pkg::arp_req;
            else
              state <= meas_pkg::send_v4;
          end
        end
        default: state <= meas_pkg::idle;
      endcase
    end
  end

endmodule

// ==== hw/apb_regs.sv ====
`timescale 1ns/1ps

module apb_regs (
  input  logic                gmii_0_tx_clk,
  input  logic                sys_rst,
  input  meas_pkg::apb_req_t  apb,
  output logic [31:0]         prdata,
  output meas_pkg::tx_cfg_t   cfg,
  output logic                req_arp,
  input  logic [47:0]         dst_mac,
  input  logic [31:0]         pps,
  input  logic [31:0]         throughput
);

  logic wr_en;

  assign wr_en = apb.sel & apb.enable & apb.write;  // Access phase of a write

  always_ff @(posedge gmii_0_tx_clk) begin
    if (sys_rst) begin
      cfg           <= '0;
      cfg.frame_len <= meas_pkg::min_frame_len;
      cfg.ifg       <= meas_pkg::min_ifg;
      req_arp       <= 1'b0;
    end else begin
      req_arp <= 1'b0;  // Single cycle pulse
      if (wr_en) begin
        case (meas_pkg::reg_addr_e'(apb.addr))
          meas_pkg::ctrl: begin
            cfg.enable <= apb.wdata[0];
            req_arp    <= apb.wdata[1];
          end
          meas_pkg::frame_len: begin
            if (apb.wdata < meas_pkg::min_frame_len)
              cfg.frame_len <= meas_pkg::min_frame_len;
            else if (apb.wdata > meas_pkg::max_frame_len)
              cfg.frame_len <= meas_pkg::max_frame_len;
            else
              cfg.frame_len <= apb.wdata[15:0];
          end
          meas_pkg::ifg:
            cfg.ifg <= (apb.wdata < meas_pkg::min_ifg) ? meas_pkg::min_ifg : apb.wdata;
          meas_pkg::src_mac_hi: cfg.src_mac[47:32] <= apb.wdata[15:0];
          meas_pkg::src_mac_lo: cfg.src_mac[31:0]  <= apb.wdata;
          meas_pkg::src_ip:     cfg.src_ip         <= apb.wdata;
          meas_pkg::gw_ip:      cfg.gw_ip          <= apb.wdata;
          meas_pkg::dst_ip:     cfg.dst_ip         <= apb.wdata;
          default: ;                               // Read only or unmapped
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read data
  // ----------------------------------------------------------------------
  always_comb begin
    case (meas_pkg::reg_addr_e'(apb.addr))
      meas_pkg::ctrl:       prdata = {31'h0, cfg.enable};  // req_arp reads 0
      meas_pkg::frame_len:  prdata = {16'h0, cfg.frame_len};
      meas_pkg::ifg:        prdata = cfg.ifg;
      meas_pkg::src_mac_hi: prdata = {16'h0, cfg.src_mac[47:32]};
      meas_pkg::src_mac_lo: prdata = cfg.src_mac[31:0];
      meas_pkg::src_ip:     prdata = cfg.src_ip;
      meas_pkg::gw_ip:      prdata = cfg.gw_ip;
      meas_pkg::dst_ip:     prdata = cfg.dst_ip;
      meas_pkg::dst_mac_hi: prdata = {16'h0, dst_mac[47:32]};
      meas_pkg::dst_mac_lo: prdata = dst_mac[31:0];
      meas_pkg::pps:        prdata = pps;
      meas_pkg::throughput: prdata = throughput;
      default:              prdata = 32'h0;
    endcase
  end

endmodule

// ==== hw/crc32_gen.sv ====
`timescale 1ns/1ps

module crc32_gen (
  input  logic        gmii_0_tx_clk,
  input  logic        sys_rst,
  input  logic        init,
  input  logic        data_en,
  input  logic [7:0]  data,
  output logic [31:0] crc
);

  logic [31:0] crc_reg;

  // Reflected polynomial, one byte LSB first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++) begin
      r = (r[0] ^ d[i]) ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge gmii_0_tx_clk) begin
    if (sys_rst || init)
      crc_reg <= 32'hFFFFFFFF;
    else if (data_en)
      crc_reg <= crc_byte(crc_reg, data);
  end

  // Complemented, first wire byte in the top lane
  assign crc = ~{crc_reg[7:0], crc_reg[15:8], crc_reg[23:16], crc_reg[31:24]};

endmodule

// ==== hw/net_pkg.sv ====
package net_pkg;

  typedef struct packed {
    logic       en;
    logic [7:0] data;
  } gmii_byte_t;

  localparam logic [15:0] ethertype_ipv4 = 16'h0800;
  localparam logic [15:0] ethertype_arp  = 16'h0806;

  typedef enum logic [15:0] {
    request = 16'd1,
    reply   = 16'd2
  } arp_op_e;

  localparam logic [7:0] preamble_byte = 8'h55;
  localparam logic [7:0] sfd_byte      = 8'hD5;

  // ----------------------------------------------------------------------
  // Test frame fields
  // ----------------------------------------------------------------------
  localparam logic [15:0] udp_port        = 16'd3422;
  localparam logic [7:0]  ipv4_ttl        = 8'd64;
  localparam logic [7:0]  ip_proto_udp    = 8'h11;
  localparam logic [39:0] magic_code      = 40'hCC00CC00CC;
  localparam logic [15:0] arp_frame_len   = 16'd64;
  localparam logic [15:0] ipv4_hdr_offset = 16'd18;   // Ethernet header and FCS
  localparam logic [15:0] udp_len_offset  = 16'd38;

  // Receive offsets from the first destination MAC byte
  localparam int rx_off_src_mac   = 6;
  localparam int rx_off_type      = 12;
  localparam int rx_off_opcode    = 20;
  localparam int rx_off_sender_ip = 28;
  localparam int rx_off_target_ip = 38;

endpackage

// ==== hw/meas_pkg.sv ====
package meas_pkg;

  // ----------------------------------------------------------------------
  // APB register map
  // ----------------------------------------------------------------------
  typedef enum logic [7:0] {
    ctrl       = 8'h00,  // bit0 enable, bit1 req_arp
    frame_len  = 8'h04,
    ifg        = 8'h08,
    src_mac_hi = 8'h0C,  // Upper 16 bits
    src_mac_lo = 8'h10,
    src_ip     = 8'h14,
    gw_ip      = 8'h18,
    dst_ip     = 8'h1C,
    dst_mac_hi = 8'h20,  // Read only
    dst_mac_lo = 8'h24,  // Read only
    pps        = 8'h28,  // Read only
    throughput = 8'h2C   // Read only
  } reg_addr_e;

  typedef struct packed {
    logic        sel;
    logic        enable;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } apb_req_t;

  typedef struct packed {
    logic        enable;
    logic [47:0] src_mac;
    logic [31:0] src_ip;
    logic [31:0] gw_ip;
    logic [31:0] dst_ip;
    logic [15:0] frame_len;
    logic [31:0] ifg;
  } tx_cfg_t;

  typedef enum logic [2:0] {
    idle,
    arp_req,
    arp_wait,
    send_v4,
    gap
  } tx_state_e;

  localparam int unsigned one_sec_cycles  = 125_000_000;
  localparam int unsigned arp_wait_cycles = 2048;          // Reply timeout
  localparam logic [31:0] min_ifg         = 32'd12;
  localparam logic [15:0] min_frame_len   = 16'd64;
  localparam logic [15:0] max_frame_len   = 16'd1518;
  localparam logic [15:0] preamble_len    = 16'd8;         // Including SFD

endpackage
